// ==== video_pkg.sv ====
package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // pixel and channel widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  cam_byte_t;             // one camera byte
    typedef logic [15:0] rgb565_t;               // stored pixel, r5 g6 b5
    typedef logic [7:0]  chan8_t;                // one output channel

    localparam int LINE_PIXELS = 8;              // pixels per line, store depth
    typedef logic [2:0]  col_t;                  // column index into the store

    // write pointer needs one extra code to saturate at LINE_PIXELS
    typedef logic [$clog2(LINE_PIXELS):0] wptr_t;
    localparam wptr_t WPTR_END = wptr_t'(LINE_PIXELS);

    //////////////////////////////////////////////////////////////////////
    // raster
    //////////////////////////////////////////////////////////////////////

    localparam int H_ACTIVE = LINE_PIXELS;       // visible columns
    localparam int H_TOTAL  = 12;                // cycles per line
    localparam int HS_WIDTH = 2;                 // hsync high at line start
    localparam int V_ACTIVE = 3;                 // visible lines
    localparam int V_TOTAL  = 5;                 // lines per frame
    localparam int VS_WIDTH = 1;                 // vsync high, whole lines

    typedef logic [3:0] hcnt_t;                  // 0 .. H_TOTAL-1
    typedef logic [2:0] vcnt_t;                  // 0 .. V_TOTAL-1

    //////////////////////////////////////////////////////////////////////
    // misc
    //////////////////////////////////////////////////////////////////////

    localparam int HEARTBEAT_CYCLES = 200;       // cycles between toggles
    typedef logic [$clog2(HEARTBEAT_CYCLES)-1:0] hb_cnt_t;
    localparam hb_cnt_t HB_LAST = hb_cnt_t'(HEARTBEAT_CYCLES - 1);

    localparam int OUT_LATENCY = 2;              // raster position to pins

    typedef enum logic {
        SCAN_WAIT,                               // no complete line yet
        SCAN_RUN                                 // free-running raster
    } scan_state_t;

endpackage

// ==== pix_if.sv ====
`timescale 1ns/1ps

// write side of the line store, one strobe per packed pixel
interface pix_wr_if import video_pkg::*;
();
    logic    wr_valid;                           // one-cycle pulse per pixel
    rgb565_t wr_data;                            // pixel already in r-g-b order
    logic    wr_first;                           // first pixel after href rise
    logic    wr_vsync;                           // registered camera vsync level

    modport drive (
        output wr_valid,
        output wr_data,
        output wr_first,
        output wr_vsync
    );

    modport recv (
        input  wr_valid,
        input  wr_data,
        input  wr_first,
        input  wr_vsync
    );
endinterface

// read side, scan_out fetches by column
interface pix_rd_if import video_pkg::*;
();
    logic    rd_en;                              // fetch request
    col_t    rd_addr;                            // column to fetch
    rgb565_t rd_data;                            // valid one cycle after rd_en
    logic    line_ready;                         // sticky, a full line was stored

    modport fetch (output rd_en, output rd_addr, input rd_data, input line_ready);

    modport serve (input rd_en, input rd_addr, output rd_data, output line_ready);
endinterface

// ==== pixel_pack.sv ====
`timescale 1ns/1ps

module pixel_pack import video_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_n_i,
    input  logic      cam_vsync_i,
    input  logic      cam_href_i,
    input  cam_byte_t cam_data_i,
    pix_wr_if.drive   wr
);

    logic        vsync_q;                        // camera inputs, one register
    logic        href_q;
    cam_byte_t   data_q;
    cam_byte_t   hi_q;                           // high byte waiting for its pair
    logic        phase_q;                        // 1 = next byte is the low byte
    logic        first_q;                        // no pair emitted since href rose
    logic        valid_q;
    logic        wfirst_q;
    rgb565_t     pix_q;
    logic [15:0] cam_word;
    logic        take_lo;

    //////////////////////////////////////////////////////////////////////
    // input register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
        end
        else
        begin
            vsync_q <= cam_vsync_i;
            href_q  <= cam_href_i;
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_q <= cam_data_i;                    // payload, sampled every cycle
    end

    //////////////////////////////////////////////////////////////////////
    // byte pairing
    //////////////////////////////////////////////////////////////////////

    assign take_lo  = href_q && phase_q;         // second byte of a pair
    assign cam_word = {hi_q, data_q};

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            phase_q  <= 1'b0;
            first_q  <= 1'b1;
            valid_q  <= 1'b0;
            wfirst_q <= 1'b0;
        end
        else
        begin
            phase_q  <= href_q ? ~phase_q : 1'b0;  // href low realigns to high byte
            valid_q  <= take_lo;
            wfirst_q <= take_lo && first_q;
            if (!href_q)
            begin
                first_q <= 1'b1;                 // rearm for the next line
            end
            else if (take_lo)
            begin
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (href_q && !phase_q)
        begin
            hi_q <= data_q;
        end
        if (take_lo)
        begin
            // camera low 5 bits are red, high 5 bits are blue
            pix_q <= {cam_word[4:0], cam_word[10:5], cam_word[15:11]};
        end
    end

    assign wr.wr_valid = valid_q;
    assign wr.wr_data  = pix_q;
    assign wr.wr_first = wfirst_q;
    assign wr.wr_vsync = vsync_q;

    // pairs need two bytes, so strobes can never be back to back
    a_valid_gap: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        wr.wr_valid |=> !wr.wr_valid);

endmodule

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store import video_pkg::*;
(
    input  logic    core_clk,
    input  logic    rst_n_i,
    pix_wr_if.recv  wr,
    pix_rd_if.serve rd
);

    rgb565_t mem [LINE_PIXELS];                  // one line of pixels
    wptr_t   wr_ptr_q;                           // saturates at WPTR_END
    wptr_t   wr_addr;
    logic    wr_ok;
    logic    ready_q;
    rgb565_t rd_data_q;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    assign wr_addr = wr.wr_first ? '0 : wr_ptr_q;        // first pixel lands at col 0
    assign wr_ok   = wr.wr_valid && (wr_addr < WPTR_END); // drop writes past the end

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            ready_q  <= 1'b0;
        end
        else
        begin
            if (wr.wr_vsync)
            begin
                wr_ptr_q <= '0;                  // frame start
            end
            else if (wr_ok)
            begin
                wr_ptr_q <= wr_addr + 1'b1;
            end
            if (wr_ok && (wr_addr == WPTR_END - 1'b1))
            begin
                ready_q <= 1'b1;                 // sticky until reset
            end
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (wr_ok)
        begin
            mem[col_t'(wr_addr)] <= wr.wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (rd.rd_en)
        begin
            rd_data_q <= mem[rd.rd_addr];        // one cycle read
        end
    end

    assign rd.rd_data    = rd_data_q;
    assign rd.line_ready = ready_q;

    // scan_out must hold off until a full line sits in the store
    a_rd_after_ready: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        rd.rd_en |-> rd.line_ready);

endmodule

// ==== scan_out.sv ====
`timescale 1ns/1ps

module scan_out import video_pkg::*;
(
    input  logic     core_clk,
    input  logic     rst_n_i,
    pix_rd_if.fetch  rd,
    output logic     vs_o,
    output logic     hs_o,
    output logic     de_o,
    output chan8_t   r_o,
    output chan8_t   g_o,
    output chan8_t   b_o
);

    scan_state_t state_q;
    hcnt_t       hcnt_q;
    vcnt_t       vcnt_q;
    logic        run;
    logic        h_act;
    logic        v_act;
    logic        vs_c;
    logic        hs_c;
    logic        de_c;
    logic [2:0]  sync_dly [OUT_LATENCY-1];       // {vs, hs, de}, matches read latency
    logic [2:0]  sync_al;

    //////////////////////////////////////////////////////////////////////
    // FSM and raster counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= SCAN_WAIT;
        end
        else if ((state_q == SCAN_WAIT) && rd.line_ready)
        begin
            state_q <= SCAN_RUN;                 // never leaves RUN
        end
    end

    assign run = (state_q == SCAN_RUN);

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            hcnt_q <= '0;
            vcnt_q <= '0;
        end
        else if (run)
        begin
            if (hcnt_q == hcnt_t'(H_TOTAL - 1))
            begin
                hcnt_q <= '0;
                vcnt_q <= (vcnt_q == vcnt_t'(V_TOTAL - 1)) ? '0 : vcnt_q + 1'b1;
            end
            else
            begin
                hcnt_q <= hcnt_q + 1'b1;
            end
        end
    end

    // sync and active decode, all held low while waiting
    assign hs_c  = run && (hcnt_q < hcnt_t'(HS_WIDTH));
    assign vs_c  = run && (vcnt_q < vcnt_t'(VS_WIDTH));
    assign h_act = (hcnt_q >= hcnt_t'(HS_WIDTH)) && (hcnt_q < hcnt_t'(HS_WIDTH + H_ACTIVE));
    assign v_act = (vcnt_q >= vcnt_t'(VS_WIDTH)) && (vcnt_q < vcnt_t'(VS_WIDTH + V_ACTIVE));
    assign de_c  = run && h_act && v_act;

    assign rd.rd_en   = de_c;
    assign rd.rd_addr = col_t'(hcnt_q - hcnt_t'(HS_WIDTH));   // column within the line

    //////////////////////////////////////////////////////////////////////
    // alignment and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < OUT_LATENCY - 1; i++)
            begin
                sync_dly[i] <= '0;
            end
        end
        else
        begin
            sync_dly[0] <= {vs_c, hs_c, de_c};
            for (int i = 1; i < OUT_LATENCY - 1; i++)
            begin
                sync_dly[i] <= sync_dly[i-1];
            end
        end
    end

    assign sync_al = sync_dly[OUT_LATENCY-2];    // lines up with rd_data

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vs_o <= 1'b0;
            hs_o <= 1'b0;
            de_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end
        else
        begin
            vs_o <= sync_al[2];
            hs_o <= sync_al[1];
            de_o <= sync_al[0];
            // 5-6-5 to 8-8-8 by zero fill, black outside the active area
            r_o  <= sync_al[0] ? {rd.rd_data[15:11], 3'b000} : '0;
            g_o  <= sync_al[0] ? {rd.rd_data[10:5], 2'b00} : '0;
            b_o  <= sync_al[0] ? {rd.rd_data[4:0], 3'b000} : '0;
        end
    end

    a_de_no_vs: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        de_o |-> !vs_o);

    a_hs_width: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        $rose(hs_o) |-> ##HS_WIDTH !hs_o);

endmodule

// ==== heartbeat_led.sv ====
`timescale 1ns/1ps

module heartbeat_led import video_pkg::*;
(
    input  logic core_clk,
    input  logic rst_n_i,
    output logic heartbeat_o
);

    hb_cnt_t cnt_q;                              // 0 .. HEARTBEAT_CYCLES-1
    logic    wrap;

    assign wrap = (cnt_q == HB_LAST);            // interval complete

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            cnt_q <= '0;
        end
        else if (wrap)
        begin
            cnt_q <= '0;
        end
        else
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // led is lit out of reset, then blinks
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            heartbeat_o <= 1'b1;
        end
        else if (wrap)
        begin
            heartbeat_o <= ~heartbeat_o;
        end
    end

endmodule

// ==== video_top.sv ====
`timescale 1ns/1ps

module video_top import video_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_n_i,
    input  logic      cam_vsync_i,               // camera frame sync
    input  logic      cam_href_i,                // byte valid, high during a line
    input  cam_byte_t cam_data_i,
    output logic      vs_o,
    output logic      hs_o,
    output logic      de_o,
    output chan8_t    r_o,
    output chan8_t    g_o,
    output chan8_t    b_o,
    output logic      heartbeat_o
);

    pix_wr_if wr_bus ();                         // pixel_pack -> line_store
    pix_rd_if rd_bus ();                         // scan_out <-> line_store

    pixel_pack u_pixel_pack (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .cam_vsync_i (cam_vsync_i),
        .cam_href_i  (cam_href_i),
        .cam_data_i  (cam_data_i),
        .wr          (wr_bus)
    );

    line_store u_line_store (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .wr       (wr_bus),
        .rd       (rd_bus)
    );

    scan_out u_scan_out (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .rd       (rd_bus),
        .vs_o     (vs_o),
        .hs_o     (hs_o),
        .de_o     (de_o),
        .r_o      (r_o),
        .g_o      (g_o),
        .b_o      (b_o)
    );

    heartbeat_led u_heartbeat_led (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .heartbeat_o (heartbeat_o)
    );

endmodule

// ==== video_checker.sv ====
`timescale 1ns/1ps

module video_checker import video_pkg::*;
(
    input  logic        core_clk,
    input  logic        rst_n_i,
    input  logic        vs_i,                    // DUT outputs under watch
    input  logic        hs_i,
    input  logic        de_i,
    input  chan8_t      r_i,
    input  chan8_t      g_i,
    input  chan8_t      b_i,
    input  logic        heartbeat_i,
    input  logic        line_done_i,             // one-cycle pulse once the line is written
    input  int          test_num_i,
    input  logic [23:0] exp_i [LINE_PIXELS],     // expected {r, g, b} per column
    output logic        idle_done_o,
    output int          frames_done_o,
    output logic        raster_done_o,
    output logic        hb_done_o,
    output int          pass_cnt_o,
    output int          fail_cnt_o
);

    localparam int IDLE_CYCLES  = 100;
    localparam int N_FRAMES     = 3;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    int cyc = 0;                                 // free cycle stamp

    always @(posedge core_clk)
    begin
        cyc <= cyc + 1;
    end

    initial
    begin
        idle_done_o   = 1'b0;
        frames_done_o = 0;
        raster_done_o = 1'b0;
        hb_done_o     = 1'b0;
        pass_cnt_o    = 0;
        fail_cnt_o    = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // sampling helpers read on the falling edge
    //////////////////////////////////////////////////////////////////////

    function automatic logic pick(input int which);
        case (which)
            0:       return vs_i;
            1:       return hs_i;
            2:       return de_i;
            3:       return heartbeat_i;
            4:       return line_done_i;
            default: return rst_n_i;
        endcase
    endfunction

    task automatic wait_level(input int which, input logic lvl, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; (n < limit) && !ok; n++)
        begin
            @(negedge core_clk);
            ok = (pick(which) === lvl);
        end
    endtask

    task automatic wait_rise(input int which, input int limit, output bit ok);
        wait_level(which, 1'b0, limit, ok);      // low first so the edge is fresh
        if (ok)
        begin
            wait_level(which, 1'b1, limit, ok);
        end
    endtask

    task automatic wait_toggle(input int which, input int limit, output bit ok);
        logic start;
        start = pick(which);
        wait_level(which, ~start, limit, ok);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act, inout int errs);
        if (act !== exp)
        begin
            $display("Fail t=%0t signal %s expected %0h actual %0h", $time, name, exp, act);
            errs++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        if (errs == 0)
        begin
            $display("test %s: ok", name);
            pass_cnt_o++;
        end
        else
        begin
            $display("test %s: %0d error(s)", name, errs);
            fail_cnt_o++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // quiet outputs through and after reset with an empty store
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int errs;
        errs = 0;
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            @(negedge core_clk);
            check_val("vs_o", 0, vs_i, errs);
            check_val("hs_o", 0, hs_i, errs);
            check_val("de_o", 0, de_i, errs);
            check_val("heartbeat_o", 1, heartbeat_i, errs);  // lit out of reset
        end
        finish_test("idle after reset", errs);
        idle_done_o = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // one checked frame per written line
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int          errs;
        int          pix;
        int          run;                        // current de_o run length
        int          runs;                       // completed active lines
        int          tnum;
        bit          ok;
        bit          stop;
        logic [23:0] exp_q [LINE_PIXELS];
        stop = 1'b0;
        for (int f = 0; (f < N_FRAMES) && !stop; f++)
        begin
            errs = 0;
            wait_level(4, 1'b1, 4000, ok);
            if (!ok)
            begin
                $display("frame check: the testbench never reported a written line");
                fail_cnt_o++;
                stop = 1'b1;
            end
            else
            begin
                tnum  = test_num_i;
                exp_q = exp_i;
                wait_rise(0, 2 * FRAME_CYCLES, ok);          // next full frame
                if (!ok)
                begin
                    $display("frame check: vs_o did not rise after line %0d", tnum);
                    errs++;
                end
                else
                begin
                    pix  = 0;
                    run  = 0;
                    runs = 0;
                    for (int i = 0; i < FRAME_CYCLES; i++)
                    begin
                        if (i > 0)
                        begin
                            @(negedge core_clk);
                        end
                        if (de_i === 1'b1)
                        begin
                            if (pix < V_ACTIVE * LINE_PIXELS)
                            begin
                                check_val("r_o", exp_q[pix % LINE_PIXELS][23:16], r_i, errs);
                                check_val("g_o", exp_q[pix % LINE_PIXELS][15:8], g_i, errs);
                                check_val("b_o", exp_q[pix % LINE_PIXELS][7:0], b_i, errs);
                            end
                            pix++;
                            run++;
                        end
                        else if (run > 0)
                        begin
                            check_val("de_o run", LINE_PIXELS, run, errs);  // per line
                            runs++;
                            run = 0;
                        end
                    end
                    check_val("de_o lines", V_ACTIVE, runs, errs);
                    check_val("de_o pixels", V_ACTIVE * LINE_PIXELS, pix, errs);
                end
                finish_test($sformatf("frame %0d", tnum), errs);
                frames_done_o++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // raster shape
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int errs;
        int t0;
        bit ok;
        errs = 0;
        wait_rise(1, 4000, ok);                  // raster starts after first line
        if (!ok)
        begin
            $display("raster check: hs_o never rose");
            errs++;
        end
        for (int k = 0; (k < 3) && ok; k++)
        begin
            t0 = cyc;
            wait_level(1, 1'b0, H_TOTAL, ok);
            check_val("hs_o width", HS_WIDTH, cyc - t0, errs);
            if (ok)
            begin
                wait_level(1, 1'b1, H_TOTAL, ok);
                check_val("hs_o period", H_TOTAL, cyc - t0, errs);
            end
        end
        if (ok)
        begin
            wait_rise(0, 2 * FRAME_CYCLES, ok);
            t0 = cyc;
        end
        if (ok)
        begin
            wait_rise(0, 2 * FRAME_CYCLES, ok);
            check_val("vs_o period", FRAME_CYCLES, cyc - t0, errs);
        end
        if (!ok)
        begin
            $display("raster check: a sync edge did not arrive in time");
            errs++;
        end
        finish_test("raster shape", errs);
        raster_done_o = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // three heartbeat toggle intervals
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int errs;
        int t0;
        bit ok;
        errs = 0;
        wait_level(5, 1'b1, 100, ok);            // reset released
        if (ok)
        begin
            wait_toggle(3, 2 * HEARTBEAT_CYCLES, ok);
        end
        t0 = cyc;
        for (int k = 0; (k < 3) && ok; k++)
        begin
            wait_toggle(3, 2 * HEARTBEAT_CYCLES, ok);
            check_val("heartbeat_o interval", HEARTBEAT_CYCLES, cyc - t0, errs);
            t0 = cyc;
        end
        if (!ok)
        begin
            $display("heartbeat check: heartbeat_o stopped toggling");
            errs++;
        end
        finish_test("heartbeat", errs);
        hb_done_o = 1'b1;
    end

endmodule

// ==== tb_video.sv ====
`timescale 1ns/1ps

module tb_video import video_pkg::*;
();

    localparam int N_LINES      = 3;
    localparam int N_TESTS      = N_LINES + 3;   // idle, frames, raster, heartbeat
    localparam int GOLD_WORDS   = N_LINES * LINE_PIXELS * 3;
    localparam int WRITE_SETTLE = 3;             // last byte to store write

    logic        core_clk;
    logic        rst_n_i;
    logic        cam_vsync_i;
    logic        cam_href_i;
    cam_byte_t   cam_data_i;
    logic        vs_o;
    logic        hs_o;
    logic        de_o;
    chan8_t      r_o;
    chan8_t      g_o;
    chan8_t      b_o;
    logic        heartbeat_o;
    logic        line_done;
    int          test_num;
    logic [23:0] exp_cols [LINE_PIXELS];
    logic        idle_done;
    logic        raster_done;
    logic        hb_done;
    int          frames_done;
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] gold [GOLD_WORDS];              // test, camera word, colour
    bit          aborted;
    bit          ok;

    initial
    begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;         // 4 ns period
    end

    video_top DUT (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .cam_vsync_i (cam_vsync_i),
        .cam_href_i  (cam_href_i),
        .cam_data_i  (cam_data_i),
        .vs_o        (vs_o),
        .hs_o        (hs_o),
        .de_o        (de_o),
        .r_o         (r_o),
        .g_o         (g_o),
        .b_o         (b_o),
        .heartbeat_o (heartbeat_o)
    );

    video_checker u_checker (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .vs_i          (vs_o),
        .hs_i          (hs_o),
        .de_i          (de_o),
        .r_i           (r_o),
        .g_i           (g_o),
        .b_i           (b_o),
        .heartbeat_i   (heartbeat_o),
        .line_done_i   (line_done),
        .test_num_i    (test_num),
        .exp_i         (exp_cols),
        .idle_done_o   (idle_done),
        .frames_done_o (frames_done),
        .raster_done_o (raster_done),
        .hb_done_o     (hb_done),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // camera stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send_line(input int line_idx);
        int          base;
        logic [15:0] w;
        base = line_idx * LINE_PIXELS * 3;
        @(posedge core_clk);
        cam_vsync_i <= 1'b1;                     // clears the write pointer
        repeat (2) @(posedge core_clk);
        cam_vsync_i <= 1'b0;
        for (int p = 0; p < LINE_PIXELS; p++)
        begin
            w = gold[base + p * 3 + 1][15:0];
            @(posedge core_clk);
            cam_href_i <= 1'b1;
            cam_data_i <= w[15:8];               // high byte first
            @(posedge core_clk);
            cam_data_i <= w[7:0];
        end
        @(posedge core_clk);
        cam_href_i <= 1'b0;
        cam_data_i <= '0;
        repeat (WRITE_SETTLE) @(posedge core_clk);
        for (int p = 0; p < LINE_PIXELS; p++)
        begin
            exp_cols[p] <= gold[base + p * 3 + 2][23:0];
        end
        test_num  <= int'(gold[base]);
        line_done <= 1'b1;                       // hand the line to the checker
        @(posedge core_clk);
        line_done <= 1'b0;
    endtask

    function automatic int status(input int which);
        case (which)
            0:       return int'(idle_done);
            1:       return frames_done;
            default: return int'(raster_done && hb_done);
        endcase
    endfunction

    task automatic wait_status(input int which, input int target, input int limit,
                               output bit done);
        done = 1'b0;
        for (int n = 0; (n < limit) && !done; n++)
        begin
            @(posedge core_clk);
            done = (status(which) >= target);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n_i     = 1'b0;
        cam_vsync_i = 1'b0;
        cam_href_i  = 1'b0;
        cam_data_i  = '0;
        line_done   = 1'b0;
        test_num    = 0;
        aborted     = 1'b0;
        for (int p = 0; p < LINE_PIXELS; p++)
        begin
            exp_cols[p] = '0;
        end
        $readmemh("video_golden.txt", gold);
        for (int k = 0; k < N_LINES; k++)
        begin
            if (gold[k * LINE_PIXELS * 3] !== k + 1)
            begin
                $display("golden file: test %0d is missing or out of order", k + 1);
                aborted = 1'b1;
            end
        end
        repeat (3) @(posedge core_clk);
        rst_n_i <= 1'b1;
        if (!aborted)
        begin
            wait_status(0, 1, 200, ok);
            if (!ok)
            begin
                $display("timeout: the idle check did not finish");
                aborted = 1'b1;
            end
        end
        for (int k = 0; (k < N_LINES) && !aborted; k++)
        begin
            send_line(k);
            wait_status(1, k + 1, 5 * H_TOTAL * V_TOTAL, ok);
            if (!ok)
            begin
                $display("timeout: no checked frame after line %0d", k + 1);
                aborted = 1'b1;
            end
        end
        if (!aborted)
        begin
            wait_status(2, 1, 8 * HEARTBEAT_CYCLES, ok);
            if (!ok)
            begin
                $display("timeout: raster or heartbeat check did not finish");
                aborted = 1'b1;
            end
        end
        $display("tests: %0d passed, %0d failed, %0d expected", pass_cnt, fail_cnt, N_TESTS);
        if (!aborted && (fail_cnt == 0) && (pass_cnt == N_TESTS))
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== video_golden.txt ====
// columns: test number, camera word {b5, g6, r5}, expected colour {r8, g8, b8}
// eight pixels per test, in column order
01 001F F80000
01 07E0 00FC00
01 F800 0000F8
01 FFFF F8FCF8
01 0000 000000
01 0001 080000
01 0020 000400
01 0800 000008
02 1841 080818
02 3082 101030
02 6104 202060
02 C208 4040C0
02 0C10 808008
02 38A3 181438
02 7945 282878
02 F28A 5050F0
03 07FF F8FC00
03 FFE0 00FCF8
03 F81F F800F8
03 38E7 381C38
03 8C29 488488
03 5514 A0A050
03 EF9E F0F0E8
03 C82C 6004C8

// ==== src.f ====
video_pkg.sv
pix_if.sv
pixel_pack.sv
line_store.sv
scan_out.sv
heartbeat_led.sv
video_top.sv
video_checker.sv
tb_video.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_video
FILELIST = src.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
